/* verilog/rv_decode_pkg.sv */
// Decode cluster package: instruction format union, control word, ALU/compare enums, opcodes, APB offsets
`default_nettype none

package rv_decode_pkg;

  // Base opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_fence  = 7'b0001111;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;  // sub, sra, srai

  // ALU funct3
  localparam logic [2:0] f3_add  = 3'd0;
  localparam logic [2:0] f3_sll  = 3'd1;
  localparam logic [2:0] f3_slt  = 3'd2;
  localparam logic [2:0] f3_sltu = 3'd3;
  localparam logic [2:0] f3_xor  = 3'd4;
  localparam logic [2:0] f3_sr   = 3'd5;
  localparam logic [2:0] f3_or   = 3'd6;
  localparam logic [2:0] f3_and  = 3'd7;

  // Memory access size, shared by loads and stores
  localparam logic [2:0] f3_byte   = 3'd0;
  localparam logic [2:0] f3_half   = 3'd1;
  localparam logic [2:0] f3_word   = 3'd2;
  localparam logic [2:0] f3_byte_u = 3'd4;
  localparam logic [2:0] f3_half_u = 3'd5;

  localparam logic [2:0] f3_beq  = 3'd0;
  localparam logic [2:0] f3_bne  = 3'd1;
  localparam logic [2:0] f3_blt  = 3'd4;
  localparam logic [2:0] f3_bge  = 3'd5;
  localparam logic [2:0] f3_bltu = 3'd6;
  localparam logic [2:0] f3_bgeu = 3'd7;

  localparam logic [2:0] f3_fence  = 3'd0;
  localparam logic [2:0] f3_fencei = 3'd1;

  localparam logic [2:0] f3_csrrw  = 3'd1;
  localparam logic [2:0] f3_csrrs  = 3'd2;
  localparam logic [2:0] f3_csrrc  = 3'd3;
  localparam logic [2:0] f3_csrrwi = 3'd5;
  localparam logic [2:0] f3_csrrsi = 3'd6;
  localparam logic [2:0] f3_csrrci = 3'd7;

  // Fixed encodings of inst[31:7] for system calls, inst[27:7] for xret
  localparam logic [24:0] sys_ecall  = 25'h0000000;
  localparam logic [24:0] sys_ebreak = 25'h0002000;
  localparam logic [20:0] sys_xret   = 21'h004000;

  // APB register offsets
  localparam logic [3:0] reg_inst     = 4'h0;
  localparam logic [3:0] reg_status   = 4'h4;
  localparam logic [3:0] reg_res_imm  = 4'h8;
  localparam logic [3:0] reg_res_ctrl = 4'hC;

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_sll  = 4'd5,
    alu_sra  = 4'd6,
    alu_srl  = 4'd7,
    alu_slt  = 4'd8,
    alu_sltu = 4'd9,
    alu_none = 4'd15
  } alu_op_e;

  typedef enum logic [2:0] {
    cmp_none = 3'd0,
    cmp_beq  = 3'd1,
    cmp_bne  = 3'd2,
    cmp_blt  = 3'd3,
    cmp_bge  = 3'd4,
    cmp_bltu = 3'd5,
    cmp_bgeu = 3'd6
  } cmp_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // One instruction word, six ways to look at it
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_t;

  typedef struct packed {
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    logic       reg_write;
    alu_op_e    alu_op;
    cmp_op_e    cmp_op;
    logic       porta_sel;
    logic       portb_sel;
    logic       illegal;
    logic       load_store;
    logic       branch;
    logic       jump;
    logic [2:0] csr_op;  // Clear, set, write
  } dec_ctrl_t;

  typedef struct packed {
    logic [31:0] imm;
    dec_ctrl_t   ctrl;
  } dec_result_t;

endpackage

`default_nettype wire

/* verilog/titan_dc_unit.sv */
// Decode lane: combinational RV32I decode and a one-entry registered output stage
`default_nettype none

module titan_dc_unit (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        in_valid,
  input  wire rv_decode_pkg::inst_t  in_inst,
  output logic                       in_ready,
  output logic                       out_valid,
  output rv_decode_pkg::dec_result_t out_result,
  input  wire                        out_ready
);
  import rv_decode_pkg::*;

  logic [6:0] opcode;
  logic [2:0] f3;
  logic       alt;
  logic       lui;
  logic       auipc;
  logic       jal;
  logic       jalr;
  logic       is_j;
  logic       is_b;
  logic       is_ld;
  logic       is_st;
  logic       is_iop;
  logic       is_rop;
  logic       srai;
  logic       is_sys;
  logic       is_csr;
  logic       is_csri;
  logic       is_fence;
  logic       is_call;
  logic       is_break;
  logic       is_xret;
  logic       is_wr;
  cmp_op_e    cmp_raw;
  logic [31:0] imm;
  dec_ctrl_t   ctrl;

  assign opcode = in_inst.r_fmt.opcode;
  assign f3     = in_inst.r_fmt.funct3;
  assign alt    = in_inst.r_fmt.funct7 == f7_alt;

  always_comb begin
    case (f3)
      f3_beq:  cmp_raw = cmp_beq;
      f3_bne:  cmp_raw = cmp_bne;
      f3_blt:  cmp_raw = cmp_blt;
      f3_bge:  cmp_raw = cmp_bge;
      f3_bltu: cmp_raw = cmp_bltu;
      f3_bgeu: cmp_raw = cmp_bgeu;
      default: cmp_raw = cmp_none;
    endcase
  end

  assign lui    = opcode == op_lui;
  assign auipc  = opcode == op_auipc;
  assign jal    = opcode == op_jal;
  assign jalr   = opcode == op_jalr;
  assign is_j   = jal || jalr;
  assign is_b   = opcode == op_branch && cmp_raw != cmp_none;
  assign is_ld  = opcode == op_load && f3 inside {f3_byte, f3_half, f3_word, f3_byte_u, f3_half_u};
  assign is_st  = opcode == op_store && f3 inside {f3_byte, f3_half, f3_word};

  // Shift immediates carry funct7, the other immediate ops do not
  assign is_iop = opcode == op_imm &&
                  (f3 == f3_sll ? in_inst.r_fmt.funct7 == f7_base :
                   f3 == f3_sr  ? (in_inst.r_fmt.funct7 == f7_base || alt) : 1'b1);
  assign is_rop = opcode == op_reg &&
                  (in_inst.r_fmt.funct7 == f7_base || (alt && (f3 == f3_add || f3 == f3_sr)));
  assign srai   = is_iop && f3 == f3_sr && alt;

  assign is_sys   = opcode == op_system;
  assign is_csri  = is_sys && f3 inside {f3_csrrwi, f3_csrrsi, f3_csrrci};
  assign is_csr   = is_sys && (f3 inside {f3_csrrw, f3_csrrs, f3_csrrc} || is_csri);
  assign is_call  = is_sys && in_inst[31:7] == sys_ecall;
  assign is_break = is_sys && in_inst[31:7] == sys_ebreak;
  assign is_xret  = is_sys && in_inst[31:30] == 2'b00 && in_inst[27:7] == sys_xret;
  assign is_fence = opcode == op_fence && (f3 == f3_fence || f3 == f3_fencei);

  assign is_wr = lui || auipc || is_j || is_ld || is_iop || is_rop || is_csr;

  // Immediate, first match wins. J and B offsets are kept in halfwords
  always_comb begin
    if (lui || auipc)
      imm = {in_inst.u_fmt.imm, 12'h000};
    else if (jal)
      imm = {{12{in_inst.j_fmt.imm20}}, in_inst.j_fmt.imm20, in_inst.j_fmt.imm19_12,
             in_inst.j_fmt.imm11, in_inst.j_fmt.imm10_1};
    else if (srai)
      imm = {27'd0, in_inst.r_fmt.rs2};  // Shamt only, drop funct7
    else if (is_b)
      imm = {{20{in_inst.b_fmt.imm12}}, in_inst.b_fmt.imm12, in_inst.b_fmt.imm11,
             in_inst.b_fmt.imm10_5, in_inst.b_fmt.imm4_1};
    else if (is_iop || is_ld || jalr)
      imm = {{20{in_inst.i_fmt.imm[11]}}, in_inst.i_fmt.imm};
    else if (is_st)
      imm = {{20{in_inst.s_fmt.imm_hi[6]}}, in_inst.s_fmt.imm_hi, in_inst.s_fmt.imm_lo};
    else if (is_csri)
      imm = {27'd0, in_inst.i_fmt.rs1};  // zimm sits in the rs1 field
    else
      imm = 32'd0;
  end

  always_comb begin
    ctrl = '0;
    ctrl.rs1       = lui ? 5'd0 : in_inst.r_fmt.rs1;
    ctrl.rs2       = is_j ? 5'd0 : in_inst.r_fmt.rs2;
    ctrl.rd        = is_st ? 5'd0 : in_inst.r_fmt.rd;
    ctrl.reg_write = ctrl.rd != 5'd0 && is_wr;
    ctrl.cmp_op    = is_b ? cmp_raw : cmp_none;
    ctrl.porta_sel = auipc || is_j;  // PC on port A
    ctrl.portb_sel = is_iop || is_ld || is_st || jalr || lui || auipc || is_csri;
    ctrl.illegal   = !(lui || auipc || is_j || is_b || is_ld || is_st || is_iop || is_rop ||
                       is_csr || is_fence || is_call || is_break || is_xret);
    ctrl.load_store = is_ld || is_st;
    ctrl.branch    = is_b;
    ctrl.jump      = is_j;
    ctrl.csr_op    = {is_sys && f3 == f3_csrrc, is_sys && f3 == f3_csrrs,
                      is_sys && f3 == f3_csrrw};
    if (is_iop || is_rop) begin
      case (f3)
        f3_add:  ctrl.alu_op = (is_rop && alt) ? alu_sub : alu_add;
        f3_sll:  ctrl.alu_op = alu_sll;
        f3_slt:  ctrl.alu_op = alu_slt;
        f3_sltu: ctrl.alu_op = alu_sltu;
        f3_xor:  ctrl.alu_op = alu_xor;
        f3_sr:   ctrl.alu_op = alt ? alu_sra : alu_srl;
        f3_or:   ctrl.alu_op = alu_or;
        default: ctrl.alu_op = alu_and;
      endcase
    end else if (lui || auipc || is_j || is_ld || is_st) begin
      ctrl.alu_op = alu_add;  // Address and link arithmetic
    end else begin
      ctrl.alu_op = alu_none;
    end
  end

  // Output stage refills in the cycle it drains
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_result <= {imm, ctrl};
    end
  end

  a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_result));

  a_illegal_no_write: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> !(out_result.ctrl.illegal && out_result.ctrl.reg_write));

endmodule

`default_nettype wire

/* verilog/inst_dispatch.sv */
// Instruction queue with round-robin issue to the decode lanes
`default_nettype none

module inst_dispatch #(
  parameter int NUM_LANES   = 4,
  parameter int QUEUE_DEPTH = 4
) (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire                                  push,
  input  wire rv_decode_pkg::inst_t            push_inst,
  output logic                                 full,
  output logic [NUM_LANES-1:0]                 lane_valid,
  output rv_decode_pkg::inst_t [NUM_LANES-1:0] lane_inst,
  input  wire [NUM_LANES-1:0]                  lane_ready
);
  import rv_decode_pkg::*;

  localparam int AW = $clog2(QUEUE_DEPTH);
  localparam int LW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  inst_t         mem [QUEUE_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic [LW-1:0] lane_ptr;
  logic          empty;
  logic          issue;

  assign empty = count == '0;
  assign full  = count == (AW+1)'(QUEUE_DEPTH);
  assign issue = !empty && lane_ready[lane_ptr];

  // Head goes to every lane, only the pointed one sees valid
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_valid[i] = !empty && lane_ptr == LW'(i);
      lane_inst[i]  = mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_inst;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      lane_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (issue) begin
        rd_ptr   <= rd_ptr + 1'b1;
        lane_ptr <= (lane_ptr == LW'(NUM_LANES - 1)) ? '0 : lane_ptr + 1'b1;
      end
      case ({push, issue})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);

  a_one_lane: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(lane_valid));

endmodule

`default_nettype wire

/* verilog/result_collect.sv */
// Round-robin lane drain into the in-order result queue
`default_nettype none

module result_collect #(
  parameter int NUM_LANES   = 4,
  parameter int QUEUE_DEPTH = 4
) (
  input  wire                                        clk,
  input  wire                                        rst_n,
  input  wire [NUM_LANES-1:0]                        lane_valid,
  input  wire rv_decode_pkg::dec_result_t [NUM_LANES-1:0] lane_result,
  output logic [NUM_LANES-1:0]                       lane_ready,
  input  wire                                        pop,
  output rv_decode_pkg::dec_result_t                 head,
  output logic                                       empty,
  output logic [3:0]                                 count
);
  import rv_decode_pkg::*;

  localparam int AW = $clog2(QUEUE_DEPTH);
  localparam int LW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  dec_result_t   mem [QUEUE_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   fill;
  logic [LW-1:0] lane_ptr;
  logic          full;
  logic          take;

  assign empty = fill == '0;
  assign full  = fill == (AW+1)'(QUEUE_DEPTH);
  assign count = 4'(fill);
  assign head  = mem[rd_ptr];
  assign take  = !full && lane_valid[lane_ptr];

  // Draining in issue order keeps results in program order
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_ready[i] = !full && lane_ptr == LW'(i);
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      mem[wr_ptr] <= lane_result[lane_ptr];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      lane_ptr <= '0;
    end else begin
      if (take) begin
        wr_ptr   <= wr_ptr + 1'b1;
        lane_ptr <= (lane_ptr == LW'(NUM_LANES - 1)) ? '0 : lane_ptr + 1'b1;
      end
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({take, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

`default_nettype wire

/* verilog/apb_decode_regs.sv */
// APB slave for the decode cluster: register decode, queue strobes, read mux, error response
`default_nettype none

module apb_decode_regs (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire [3:0]                       paddr,
  input  wire                             psel,
  input  wire                             penable,
  input  wire                             pwrite,
  input  wire [31:0]                      pwdata,
  output logic [31:0]                     prdata,
  output logic                            pready,
  output logic                            pslverr,
  output logic                            inst_push,
  output rv_decode_pkg::inst_t            inst_data,
  input  wire                             in_full,
  input  wire rv_decode_pkg::dec_result_t res_head,
  input  wire                             res_empty,
  input  wire [3:0]                       res_count,
  output logic                            res_pop
);
  import rv_decode_pkg::*;

  logic access;
  logic wr_inst;
  logic rd_result;

  assign access    = psel && penable;
  assign wr_inst   = access && pwrite && paddr == reg_inst;
  assign rd_result = access && !pwrite && (paddr == reg_res_imm || paddr == reg_res_ctrl);

  assign pready    = 1'b1;  // Zero wait states
  assign inst_data = pwdata;
  assign inst_push = wr_inst && !in_full;
  assign res_pop   = access && !pwrite && paddr == reg_res_ctrl && !res_empty;
  assign pslverr   = (wr_inst && in_full) || (rd_result && res_empty);

  always_comb begin
    case (paddr)
      reg_status:   prdata = {20'd0, res_count, 6'd0, res_empty, in_full};
      reg_res_imm:  prdata = res_head.imm;
      reg_res_ctrl: prdata = res_head.ctrl;
      default:      prdata = 32'd0;  // reg_inst and holes
    endcase
  end

  // Setup phase is always followed by an access to the same address
  a_apb_access: assert property (@(posedge clk) disable iff (!rst_n)
    psel && !penable |=> psel && penable && $stable(paddr) && $stable(pwrite));

endmodule

`default_nettype wire

/* verilog/decode_cluster_top.sv */
// Decode cluster top: APB slave, dispatcher, decode lanes and result collector
`default_nettype none

module decode_cluster_top #(
  parameter int NUM_LANES   = 4,
  parameter int QUEUE_DEPTH = 4
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire [3:0]  paddr,
  input  wire        psel,
  input  wire        penable,
  input  wire        pwrite,
  input  wire [31:0] pwdata,
  output logic [31:0] prdata,
  output logic       pready,
  output logic       pslverr
);
  import rv_decode_pkg::*;

  logic                          inst_push;
  inst_t                         inst_data;
  logic                          in_full;
  dec_result_t                   res_head;
  logic                          res_empty;
  logic [3:0]                    res_count;
  logic                          res_pop;
  logic [NUM_LANES-1:0]          lane_in_valid;
  inst_t [NUM_LANES-1:0]         lane_in_inst;
  logic [NUM_LANES-1:0]          lane_in_ready;
  logic [NUM_LANES-1:0]          lane_out_valid;
  dec_result_t [NUM_LANES-1:0]   lane_out_result;
  logic [NUM_LANES-1:0]          lane_out_ready;

  apb_decode_regs apb_decode_regs_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .inst_push (inst_push),
    .inst_data (inst_data),
    .in_full   (in_full),
    .res_head  (res_head),
    .res_empty (res_empty),
    .res_count (res_count),
    .res_pop   (res_pop)
  );

  inst_dispatch #(
    .NUM_LANES   (NUM_LANES),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) inst_dispatch_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (inst_push),
    .push_inst  (inst_data),
    .full       (in_full),
    .lane_valid (lane_in_valid),
    .lane_inst  (lane_in_inst),
    .lane_ready (lane_in_ready)
  );

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    titan_dc_unit titan_dc_unit_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (lane_in_valid[g]),
      .in_inst    (lane_in_inst[g]),
      .in_ready   (lane_in_ready[g]),
      .out_valid  (lane_out_valid[g]),
      .out_result (lane_out_result[g]),
      .out_ready  (lane_out_ready[g])
    );
  end

  result_collect #(
    .NUM_LANES   (NUM_LANES),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) result_collect_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .lane_valid  (lane_out_valid),
    .lane_result (lane_out_result),
    .lane_ready  (lane_out_ready),
    .pop         (res_pop),
    .head        (res_head),
    .empty       (res_empty),
    .count       (res_count)
  );

endmodule

`default_nettype wire

/* tb/tb_decode_cluster.sv */
// Testbench for the decode cluster: per-vector decode checks, in-order bursts, back-pressure, APB errors
`default_nettype none

module tb_decode_cluster;
  timeunit 1ns;
  timeprecision 100ps;

  import rv_decode_pkg::*;

  localparam int num_lanes   = 4;
  localparam int queue_depth = 4;
  localparam int poll_limit  = 64;
  // Input queue, one per lane, result queue, then the refused one
  localparam int full_write  = queue_depth + num_lanes + queue_depth + 1;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [3:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  logic [31:0] stim_inst [$];
  logic [31:0] stim_imm  [$];
  logic [31:0] stim_ctrl [$];
  int          pending   [$];  // Stimulus indices still to be read, in write order

  decode_cluster_top #(
    .NUM_LANES   (num_lanes),
    .QUEUE_DEPTH (queue_depth)
  ) decode_cluster_top_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #4 clk = ~clk;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      report_error($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                             $time, name, got, exp));
    end
  endtask

  // One APB transfer, setup then a single access cycle
  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);  // Mid access phase
    check_value("pready", 32'(pready), 32'd1);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic read_status(output logic [31:0] status);
    logic err;
    apb_access(1'b0, reg_status, 32'd0, status, err);
    check_value("pslverr", 32'(err), 32'd0);
  endtask

  task automatic send_inst(input int idx);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, reg_inst, stim_inst[idx], rdata, err);
    check_value("pslverr", 32'(err), 32'd0);
    pending.push_back(idx);
  endtask

  task automatic wait_result();
    logic [31:0] status;
    int          polls = 0;
    read_status(status);
    while (status[1]) begin  // Result queue empty
      polls++;
      if (polls == poll_limit) report_error("timeout: result queue stayed empty");
      read_status(status);
    end
  endtask

  // Oldest outstanding instruction must be at the queue head
  task automatic check_result();
    logic [31:0] rdata;
    logic        err;
    int          idx;
    idx = pending.pop_front();
    wait_result();
    apb_access(1'b0, reg_res_imm, 32'd0, rdata, err);
    check_value("pslverr", 32'(err), 32'd0);
    check_value("res_imm", rdata, stim_imm[idx]);
    apb_access(1'b0, reg_res_ctrl, 32'd0, rdata, err);
    check_value("pslverr", 32'(err), 32'd0);
    check_value("res_ctrl", rdata, stim_ctrl[idx]);
  endtask

  task automatic load_stimulus();
    int          fd;
    string       line;
    logic [31:0] inst;
    logic [31:0] imm;
    logic [31:0] ctrl;
    fd = $fopen("tb/decode_stimulus.txt", "r");
    if (fd == 0) report_error("cannot open tb/decode_stimulus.txt");
    while (!$feof(fd)) begin
      if ($fgets(line, fd) != 0 && line.len() > 0 && line.getc(0) != "#") begin
        if ($sscanf(line, "%h %h %h", inst, imm, ctrl) == 3) begin
          stim_inst.push_back(inst);
          stim_imm.push_back(imm);
          stim_ctrl.push_back(ctrl);
        end
      end
    end
    $fclose(fd);
    if (stim_inst.size() == 0) report_error("stimulus file holds no vectors");
  endtask

  initial begin
    logic [31:0] status;
    logic [31:0] rdata;
    logic        err;
    int          burst_len;
    int          next_idx;
    int          writes;
    bit          refused;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = 4'h0;
    pwdata  = 32'd0;
    void'($urandom(35839));
    load_stimulus();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    read_status(status);
    check_value("status", status, 32'h0000_0002);  // Empty, count 0

    for (int i = 0; i < stim_inst.size(); i++) begin
      send_inst(i);
      check_result();
    end

    // Bursts spread over the lanes
    next_idx = 0;
    for (int b = 0; b < 6; b++) begin
      burst_len = 1 + int'($urandom % 8);
      for (int i = 0; i < burst_len; i++) begin
        send_inst(next_idx);
        next_idx = (next_idx + 1) % stim_inst.size();
      end
      while (pending.size() != 0) check_result();
    end

    // No reads, so every stage fills up
    writes  = 0;
    refused = 1'b0;
    while (!refused) begin
      writes++;
      if (writes > 2 * full_write) report_error("timeout: writes were never refused");
      apb_access(1'b1, reg_inst, stim_inst[next_idx], rdata, err);
      if (err) begin
        refused = 1'b1;
      end else begin
        pending.push_back(next_idx);
        next_idx = (next_idx + 1) % stim_inst.size();
      end
    end
    check_value("refused_write", 32'(writes), 32'(full_write));
    read_status(status);
    check_value("status", status, {20'd0, 4'(queue_depth), 6'd0, 1'b0, 1'b1});
    while (pending.size() != 0) check_result();

    apb_access(1'b0, reg_res_ctrl, 32'd0, rdata, err);
    check_value("pslverr", 32'(err), 32'd1);
    read_status(status);
    check_value("status", status, 32'h0000_0002);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/decode_stimulus.txt */
# Columns: instruction, expected immediate, expected control word (all hex)
# Control word from bit 31: rs1 rs2 rd reg_write alu_op cmp_op porta portb illegal ls br jump csr_op
123452b7 12345000 00cb0080  # lui x5, 0x12345
00001097 00001000 00030180  # auipc x1, 0x1
008000ef 00000004 00030108  # jal x1, +8 (offset in halfwords)
00008067 00000000 08000188  # jalr x0, 0(x1)
00208863 00000008 08a0f210  # beq x1, x2, +16
fe019ee3 fffffffe 183af410  # bne x3, x0, -4
00812303 00000008 120d00a0  # lw x6, 8(x2)
fff08003 ffffffff 0fc000a0  # lb x0, -1(x1)
00512623 0000000c 114000a0  # sw x5, 12(x2)
fe719f23 fffffffe 19c000a0  # sh x7, -2(x3)
ffb00093 fffffffb 06c30080  # addi x1, x0, -5
0012b213 00000001 28499080  # sltiu x4, x5, 1
4071d193 00000007 19c76080  # srai x3, x3, 7
00309113 00000003 08c55080  # slli x2, x1, 3
00c58533 00000000 5b150000  # add x10, x11, x12
40208033 00000000 08801000  # sub x0, x1, x2
407352b3 00000000 31cb6000  # sra x5, x6, x7
00a4f433 00000000 4a912000  # and x8, x9, x10
0ff0000f 00000000 07c0f000  # fence
0000100f 00000000 0000f000  # fence.i
00000073 00000000 0000f000  # ecall
00100073 00000000 0040f000  # ebreak
30200073 00000000 0080f000  # mret
300110f3 00000000 1003f001  # csrrw x1, mstatus, x2
3052e1f3 00000005 2947f080  # csrrsi x3, mtvec, 5
00000000 00000000 0000f040  # illegal, all zeros
ffffffff 00000000 fffef040  # illegal, all ones

/* run_sim.sh */
#!/bin/sh
# Compile the decode cluster testbench with Verilator, run it and search the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_decode_cluster -f sources.f -o tb_decode_cluster

./obj_dir/tb_decode_cluster | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* sources.f */
verilog/rv_decode_pkg.sv
verilog/titan_dc_unit.sv
verilog/inst_dispatch.sv
verilog/result_collect.sv
verilog/apb_decode_regs.sv
verilog/decode_cluster_top.sv
tb/tb_decode_cluster.sv
